// ==== hw/backend_pkg.sv ====
/* back end shared types */

package backend_pkg;

    // data ram depth in words
    localparam int RAM_WORDS = 256;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [7:0]  ram_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // same coding as the funct3 of loads and stores
    typedef enum logic [2:0] {
        SIZE_B  = 3'd0,
        SIZE_H  = 3'd1,
        SIZE_W  = 3'd2,
        SIZE_BU = 3'd4,
        SIZE_HU = 3'd5
    } mem_size_e;

    typedef enum logic [0:0] {
        ST_IDLE = 1'b0,
        ST_BUS  = 1'b1
    } mem_state_e;

    // decoded micro-op from the decoder
    typedef struct packed {
        word_t     pc;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
        logic      use_imm;
        alu_op_e   alu_op;
        reg_addr_t rd;
        logic      rd_write;
        mem_op_e   mem_op;
        mem_size_e mem_size;
        logic      is_jump;
        logic      is_break;
    } uop_t;

    // execute result, held in the pipeline register
    typedef struct packed {
        word_t     alu_result;
        word_t     store_data;
        word_t     npc;
        logic      redirect;
        reg_addr_t rd;
        logic      rd_write;
        mem_op_e   mem_op;
        mem_size_e mem_size;
        logic      is_break;
    } exe_rec_t;

    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

// ==== hw/exe_unit.sv ====
/* execute stage */

`timescale 1ns/100ps

module exe_unit (
    input  logic                  in_valid_i,
    input  backend_pkg::uop_t     uop_i,
    output logic                  in_ready_o,
    output logic                  out_valid_o,
    output backend_pkg::exe_rec_t rec_o,
    input  logic                  out_ready_i
);
    import backend_pkg::*;

    word_t op_b;
    word_t alu_out;
    word_t addr_sum;
    word_t link_pc;

    // no storage here, handshake passes straight through
    assign out_valid_o = in_valid_i;
    assign in_ready_o  = out_ready_i;

    assign op_b     = uop_i.use_imm ? uop_i.imm : uop_i.rs2_val;
    // memory address and jump target share this adder
    assign addr_sum = uop_i.rs1_val + uop_i.imm;
    assign link_pc  = uop_i.pc + 32'd4;

    always_comb begin
        case (uop_i.alu_op)
            ALU_ADD:  alu_out = uop_i.rs1_val + op_b;
            ALU_SUB:  alu_out = uop_i.rs1_val - op_b;
            ALU_AND:  alu_out = uop_i.rs1_val & op_b;
            ALU_OR:   alu_out = uop_i.rs1_val | op_b;
            ALU_XOR:  alu_out = uop_i.rs1_val ^ op_b;
            ALU_SLL:  alu_out = uop_i.rs1_val << op_b[4:0];
            ALU_SRL:  alu_out = uop_i.rs1_val >> op_b[4:0];
            ALU_SRA:  alu_out = word_t'($signed(uop_i.rs1_val) >>> op_b[4:0]);
            ALU_SLT: begin
                alu_out = {31'd0, $signed(uop_i.rs1_val) < $signed(op_b)};
            end
            ALU_SLTU: begin
                alu_out = {31'd0, uop_i.rs1_val < op_b};
            end
            default:  alu_out = '0;
        endcase
    end

    always_comb begin
        // jumps write the link address, memory ops carry the address
        if (uop_i.is_jump) begin
            rec_o.alu_result = link_pc;
        end else if (uop_i.mem_op != MEM_NONE) begin
            rec_o.alu_result = addr_sum;
        end else begin
            rec_o.alu_result = alu_out;
        end

        // target with bit 0 cleared as for jalr
        if (uop_i.is_jump) begin
            rec_o.npc = {addr_sum[31:1], 1'b0};
        end else begin
            rec_o.npc = link_pc;
        end

        rec_o.redirect   = uop_i.is_jump;
        rec_o.store_data = uop_i.rs2_val;
        rec_o.rd         = uop_i.rd;
        rec_o.rd_write   = uop_i.rd_write;
        rec_o.mem_op     = uop_i.mem_op;
        rec_o.mem_size   = uop_i.mem_size;
        rec_o.is_break   = uop_i.is_break;
    end

endmodule

// ==== hw/exe_mem_reg.sv ====
/* execute to memory stage register */

`timescale 1ns/100ps

module exe_mem_reg (
    input  logic                  clk,
    input  logic                  reset,

    // from execute
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  backend_pkg::exe_rec_t rec_i,

    // to memory stage
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output backend_pkg::exe_rec_t rec_o,

    input  logic                  flush_i,

    // jump target toward fetch
    output logic                  redirect_valid_o,
    output backend_pkg::word_t    redirect_pc_o
);
    import backend_pkg::*;

    logic     valid_q;
    exe_rec_t rec_q;
    logic     load;

    // a flushed entry is never offered downstream
    assign out_valid_o = valid_q & ~flush_i;

    // slide when the held entry leaves in the same cycle
    // upstream holds during a flush so nothing is dropped
    assign in_ready_o = (~valid_q | out_ready_i) & ~flush_i;

    assign load = in_valid_i & in_ready_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rec_q <= rec_i;
        end
    end

    assign rec_o = rec_q;

    // one pulse per jump, the entry leaves on this transfer
    assign redirect_valid_o = out_valid_o & out_ready_i & rec_q.redirect;
    assign redirect_pc_o    = rec_q.npc;

endmodule

// ==== hw/mem_unit.sv ====
/* memory stage sequencer */

`timescale 1ns/100ps

module mem_unit (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  backend_pkg::exe_rec_t  rec_i,

    // wishbone classic master
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output backend_pkg::ram_addr_t wb_adr_o,
    output logic [3:0]             wb_sel_o,
    output backend_pkg::word_t     wb_dat_o,
    input  backend_pkg::word_t     wb_dat_i,
    input  logic                   wb_ack_i,

    // register write-back
    output logic                   wb_valid_o,
    output backend_pkg::wb_t       wb_o,
    output logic                   halt_o
);
    import backend_pkg::*;

    mem_state_e state_q;
    exe_rec_t   cur_q;
    logic       accept;
    logic       direct_retire;
    logic       bus_done;
    logic [1:0] byte_off;
    word_t      lane_data;
    word_t      load_data;

    // one record at a time, nothing more after ebreak
    assign in_ready_o    = (state_q == ST_IDLE) & ~halt_o;
    assign accept        = in_valid_i & in_ready_o;
    assign direct_retire = accept & (rec_i.mem_op == MEM_NONE);
    assign bus_done      = (state_q == ST_BUS) & wb_ack_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept && rec_i.mem_op != MEM_NONE) begin
                        state_q <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (wb_ack_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_q <= rec_i;
        end
    end

    // cyc and stb rise together and fall after ack
    assign wb_cyc_o = (state_q == ST_BUS);
    assign wb_stb_o = (state_q == ST_BUS);
    assign wb_we_o  = (cur_q.mem_op == MEM_STORE);
    assign wb_adr_o = cur_q.alu_result[2 +: $bits(ram_addr_t)];
    assign byte_off = cur_q.alu_result[1:0];

    // lane select and store data alignment
    always_comb begin
        case (cur_q.mem_size)
            SIZE_B, SIZE_BU: begin
                wb_sel_o = 4'b0001 << byte_off;
                wb_dat_o = cur_q.store_data << {byte_off, 3'b000};
            end
            SIZE_H, SIZE_HU: begin
                wb_sel_o = 4'b0011 << {byte_off[1], 1'b0};
                wb_dat_o = cur_q.store_data << {byte_off[1], 4'b0000};
            end
            default: begin
                wb_sel_o = 4'b1111;
                wb_dat_o = cur_q.store_data;
            end
        endcase
    end

    // load data down to bit 0, then extend
    assign lane_data = wb_dat_i >> {byte_off, 3'b000};

    always_comb begin
        case (cur_q.mem_size)
            SIZE_B:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            SIZE_BU: load_data = {24'd0, lane_data[7:0]};
            SIZE_H:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            SIZE_HU: load_data = {16'd0, lane_data[15:0]};
            default: load_data = wb_dat_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid_o <= 1'b0;
            halt_o     <= 1'b0;
        end else begin
            wb_valid_o <= (direct_retire && rec_i.rd_write && rec_i.rd != '0) ||
                          (bus_done && cur_q.mem_op == MEM_LOAD &&
                           cur_q.rd_write && cur_q.rd != '0);
            if (direct_retire && rec_i.is_break) begin
                halt_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (direct_retire) begin
            wb_o <= '{rd: rec_i.rd, data: rec_i.alu_result};
        end else if (bus_done) begin
            wb_o <= '{rd: cur_q.rd, data: load_data};
        end
    end

endmodule

// ==== hw/data_ram.sv ====
/* wishbone data ram */

`timescale 1ns/100ps

module data_ram (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  backend_pkg::ram_addr_t wb_adr_i,
    input  logic [3:0]             wb_sel_i,
    input  backend_pkg::word_t     wb_dat_i,
    output backend_pkg::word_t     wb_dat_o,
    output logic                   wb_ack_o
);
    import backend_pkg::*;

    word_t mem [RAM_WORDS];
    logic  req;

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // new request, the strobe is still up during the ack cycle
    assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req && wb_we_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wb_sel_i[lane]) begin
                    mem[wb_adr_i][8*lane +: 8] <= wb_dat_i[8*lane +: 8];
                end
            end
        end
        // read data appears together with ack
        if (req && !wb_we_i) begin
            wb_dat_o <= mem[wb_adr_i];
        end
    end

endmodule

// ==== hw/backend_top.sv ====
/* core back end top */

`timescale 1ns/100ps

module backend_top (
    input  logic                 clk,
    input  logic                 reset,

    // decoded micro-ops
    input  logic                 uop_valid_i,
    input  backend_pkg::uop_t    uop_i,
    output logic                 uop_ready_o,

    input  logic                 flush_i,

    output logic                 redirect_valid_o,
    output backend_pkg::word_t   redirect_pc_o,

    output logic                 wb_valid_o,
    output backend_pkg::wb_t     wb_o,
    output logic                 halt_o
);
    import backend_pkg::*;

    logic      exe_valid;
    logic      exe_ready;
    exe_rec_t  exe_rec;

    logic      mem_valid;
    logic      mem_ready;
    exe_rec_t  mem_rec;

    // data bus
    logic      bus_cyc;
    logic      bus_stb;
    logic      bus_we;
    ram_addr_t bus_adr;
    logic [3:0] bus_sel;
    word_t     bus_dat_w;
    word_t     bus_dat_r;
    logic      bus_ack;

    exe_unit i_exe (
        .in_valid_i (uop_valid_i),
        .uop_i      (uop_i),
        .in_ready_o (uop_ready_o),
        .out_valid_o(exe_valid),
        .rec_o      (exe_rec),
        .out_ready_i(exe_ready)
    );

    exe_mem_reg i_exe_mem (
        .clk             (clk),
        .reset           (reset),
        .in_valid_i      (exe_valid),
        .in_ready_o      (exe_ready),
        .rec_i           (exe_rec),
        .out_valid_o     (mem_valid),
        .out_ready_i     (mem_ready),
        .rec_o           (mem_rec),
        .flush_i         (flush_i),
        .redirect_valid_o(redirect_valid_o),
        .redirect_pc_o   (redirect_pc_o)
    );

    mem_unit i_mem (
        .clk       (clk),
        .reset     (reset),
        .in_valid_i(mem_valid),
        .in_ready_o(mem_ready),
        .rec_i     (mem_rec),
        .wb_cyc_o  (bus_cyc),
        .wb_stb_o  (bus_stb),
        .wb_we_o   (bus_we),
        .wb_adr_o  (bus_adr),
        .wb_sel_o  (bus_sel),
        .wb_dat_o  (bus_dat_w),
        .wb_dat_i  (bus_dat_r),
        .wb_ack_i  (bus_ack),
        .wb_valid_o(wb_valid_o),
        .wb_o      (wb_o),
        .halt_o    (halt_o)
    );

    data_ram i_ram (
        .clk     (clk),
        .reset   (reset),
        .wb_cyc_i(bus_cyc),
        .wb_stb_i(bus_stb),
        .wb_we_i (bus_we),
        .wb_adr_i(bus_adr),
        .wb_sel_i(bus_sel),
        .wb_dat_i(bus_dat_w),
        .wb_dat_o(bus_dat_r),
        .wb_ack_o(bus_ack)
    );

endmodule

// ==== verif/backend_assert.sv ====
/* back end protocol checks */

`timescale 1ns/100ps

module backend_assert (
    input logic              clk,
    input logic              reset,
    input logic              uop_valid_i,
    input logic              uop_ready_i,
    input backend_pkg::uop_t uop_i,
    input logic              cyc_i,
    input logic              stb_i,
    input logic              ack_i
);

    // wishbone classic rules on the data bus
    a_stb_cyc: assert property (@(posedge clk) disable iff (reset) stb_i |-> cyc_i)
        else $error("wishbone stb raised without cyc");

    a_ack_one: assert property (@(posedge clk) disable iff (reset) ack_i |=> !ack_i)
        else $error("wishbone ack held longer than one cycle");

    a_ack_stb: assert property (@(posedge clk) disable iff (reset) ack_i |-> stb_i)
        else $error("wishbone ack without a strobe");

    a_stb_hold: assert property (@(posedge clk) disable iff (reset)
        stb_i && !ack_i |=> stb_i)
        else $error("wishbone stb dropped before ack");

    // upstream holds its micro-op while stalled
    a_uop_hold: assert property (@(posedge clk) disable iff (reset)
        uop_valid_i && !uop_ready_i |=> uop_valid_i && $stable(uop_i))
        else $error("micro-op changed while stalled");

endmodule

// ==== verif/tb_backend.sv ====
/* back end testbench */

`timescale 1ns/100ps

module tb_backend;
    import backend_pkg::*;

    logic  clk = 1'b0;
    logic  reset;
    logic  uop_valid;
    uop_t  uop;
    logic  uop_ready;
    logic  flush;
    logic  redirect_valid;
    word_t redirect_pc;
    logic  wb_valid;
    wb_t   wb_out;
    logic  halt;

    // test lines as read from the file
    uop_t  tst_uop[$];
    logic  tst_flush[$];
    word_t tst_exp[$];
    int    n_lines = 0;

    // outstanding results in issue order
    wb_t   exp_wb[$];
    word_t exp_redirect[$];
    wb_t   exp_item;
    word_t exp_target;

    // byte image of the data ram
    logic [7:0] shadow [0:4*RAM_WORDS-1];

    int errors = 0;
    int checks = 0;

    always #4 clk = ~clk;

    backend_top i_dut (
        .clk             (clk),
        .reset           (reset),
        .uop_valid_i     (uop_valid),
        .uop_i           (uop),
        .uop_ready_o     (uop_ready),
        .flush_i         (flush),
        .redirect_valid_o(redirect_valid),
        .redirect_pc_o   (redirect_pc),
        .wb_valid_o      (wb_valid),
        .wb_o            (wb_out),
        .halt_o          (halt)
    );

    bind backend_top backend_assert i_assert (
        .clk        (clk),
        .reset      (reset),
        .uop_valid_i(uop_valid_i),
        .uop_ready_i(uop_ready_o),
        .uop_i      (uop_i),
        .cyc_i      (bus_cyc),
        .stb_i      (bus_stb),
        .ack_i      (bus_ack)
    );

    task automatic check(input string what, input word_t got, input word_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic store_shadow(input word_t addr, input word_t data, input mem_size_e size);
        int n;
        logic [9:0] a;
        a = addr[9:0];
        n = (size == SIZE_W) ? 4 : ((size == SIZE_H || size == SIZE_HU) ? 2 : 1);
        for (int i = 0; i < n; i++) begin
            shadow[a + 10'(i)] = data[8*i +: 8];
        end
    endtask

    function automatic word_t load_shadow(input word_t addr, input mem_size_e size);
        logic [9:0] a;
        word_t w;
        a = addr[9:0];
        w = {shadow[a + 10'd3], shadow[a + 10'd2], shadow[a + 10'd1], shadow[a]};
        case (size)
            SIZE_B:  return {{24{w[7]}}, w[7:0]};
            SIZE_BU: return {24'd0, w[7:0]};
            SIZE_H:  return {{16{w[15]}}, w[15:0]};
            SIZE_HU: return {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic load_tests();
        int fd;
        int cnt;
        string line;
        word_t f_fl, f_pc, f_rs1, f_rs2, f_imm, f_ui, f_op;
        word_t f_rd, f_rdw, f_mo, f_sz, f_jmp, f_brk, f_exp;
        uop_t u;
        fd = $fopen("verif/backend_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open verif/backend_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                cnt = $fgets(line, fd);
                if (cnt > 0 && line[0] != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  f_fl, f_pc, f_rs1, f_rs2, f_imm, f_ui, f_op,
                                  f_rd, f_rdw, f_mo, f_sz, f_jmp, f_brk, f_exp);
                    if (cnt == 14) begin
                        u.pc       = f_pc;
                        u.rs1_val  = f_rs1;
                        u.rs2_val  = f_rs2;
                        u.imm      = f_imm;
                        u.use_imm  = f_ui[0];
                        u.alu_op   = alu_op_e'(f_op[3:0]);
                        u.rd       = f_rd[3:0];
                        u.rd_write = f_rdw[0];
                        u.mem_op   = mem_op_e'(f_mo[1:0]);
                        u.mem_size = mem_size_e'(f_sz[2:0]);
                        u.is_jump  = f_jmp[0];
                        u.is_break = f_brk[0];
                        tst_uop.push_back(u);
                        tst_flush.push_back(f_fl[0]);
                        tst_exp.push_back(f_exp);
                    end
                end
            end
            $fclose(fd);
            n_lines = tst_uop.size();
        end
    endtask

    // expected effects of a line, taken at its transfer
    task automatic record_expect(input int idx);
        uop_t u;
        word_t model;
        u = tst_uop[idx];
        if (tst_flush[idx]) begin
            return;
        end
        if (u.is_jump) begin
            check("jump target rule", tst_exp[idx], (u.rs1_val + u.imm) & 32'hffff_fffe);
            exp_redirect.push_back(tst_exp[idx]);
            if (u.rd_write && u.rd != '0) begin
                exp_wb.push_back('{rd: u.rd, data: u.pc + 32'd4});
            end
        end else if (u.mem_op == MEM_STORE) begin
            store_shadow(u.rs1_val + u.imm, u.rs2_val, u.mem_size);
        end else if (u.mem_op == MEM_LOAD) begin
            model = load_shadow(u.rs1_val + u.imm, u.mem_size);
            check("load against memory model", tst_exp[idx], model);
            if (u.rd_write && u.rd != '0) begin
                exp_wb.push_back('{rd: u.rd, data: model});
            end
        end else if (!u.is_break && u.rd_write && u.rd != '0) begin
            exp_wb.push_back('{rd: u.rd, data: tst_exp[idx]});
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic issue_line(input int idx);
        uop       = tst_uop[idx];
        uop_valid = 1'b1;
        do begin
            @(posedge clk);
        end while (!uop_ready);
        record_expect(idx);
        @(negedge clk);
        uop_valid = 1'b0;
        if (tst_flush[idx]) begin
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
        end
    endtask

    // write-back and redirect monitor
    always @(posedge clk) begin
        if (!reset && wb_valid) begin
            if (exp_wb.size() == 0) begin
                errors++;
                $display("write-back to x%0d at %0t ns was not expected", wb_out.rd, $time);
            end else begin
                exp_item = exp_wb.pop_front();
                check("write-back register", word_t'(wb_out.rd), word_t'(exp_item.rd));
                check("write-back data", wb_out.data, exp_item.data);
            end
        end
        if (!reset && redirect_valid) begin
            if (exp_redirect.size() == 0) begin
                errors++;
                $display("redirect to %h at %0t ns was not expected", redirect_pc, $time);
            end else begin
                exp_target = exp_redirect.pop_front();
                check("redirect target", redirect_pc, exp_target);
            end
        end
    end

    initial begin
        wait (n_lines > 0);
        repeat (40 * n_lines + 10) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped making progress",
                 40 * n_lines + 10);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        uop_valid = 1'b0;
        uop       = '0;
        flush     = 1'b0;
        for (int i = 0; i < 4 * RAM_WORDS; i++) begin
            shadow[i] = 8'h00;
        end
        load_tests();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check("ready after reset", word_t'(uop_ready), 32'd1);
        check("write-back after reset", word_t'(wb_valid), 32'd0);
        check("redirect after reset", word_t'(redirect_valid), 32'd0);
        check("halt after reset", word_t'(halt), 32'd0);

        for (int i = 0; i < n_lines; i++) begin
            issue_line(i);
        end

        if (n_lines > 0) begin
            do begin
                @(posedge clk);
            end while (!halt);
            // halt holds and nothing retires after it
            repeat (4) begin
                @(posedge clk);
                check("halt held", word_t'(halt), 32'd1);
            end
        end
        if (exp_wb.size() != 0) begin
            errors++;
            $display("%0d expected write-backs never arrived", exp_wb.size());
        end
        if (exp_redirect.size() != 0) begin
            errors++;
            $display("%0d expected redirects never arrived", exp_redirect.size());
        end

        $display("%0d lines issued, %0d checks, %0d errors", n_lines, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verif/backend_tests.txt ====
# flush pc rs1 rs2 imm use_imm alu rd rd_write mem_op mem_size jump break expect (all hex)
# expect is the write-back value, or the redirect target for a jump
0 00000000 00000005 00000007 00000000 0 0 1 1 0 2 0 0 0000000c
0 00000004 0000000a 00000000 00000014 1 1 2 1 0 2 0 0 fffffff6
0 00000008 f0f0f0f0 ff00ff00 00000000 0 2 3 1 0 2 0 0 f000f000
0 0000000c 0f0f0000 000000ff 00000000 0 3 4 1 0 2 0 0 0f0f00ff
0 00000010 ffff0000 0f0f0f0f 00000000 0 4 5 1 0 2 0 0 f0f00f0f
0 00000014 00000001 00000000 0000001f 1 5 6 1 0 2 0 0 80000000
0 00000018 80000010 00000004 00000000 0 6 7 1 0 2 0 0 08000001
0 0000001c 80000010 00000004 00000000 0 7 8 1 0 2 0 0 f8000001
0 00000020 ffffffff 00000001 00000000 0 8 9 1 0 2 0 0 00000001
0 00000024 ffffffff 00000001 00000000 0 9 a 1 0 2 0 0 00000000
0 00000028 00000003 00000004 00000000 0 0 0 1 0 2 0 0 00000000
0 0000002c 00000100 8badf00d 00000000 1 0 0 0 2 2 0 0 00000000
0 00000030 00000100 000000a5 00000001 1 0 0 0 2 0 0 0 00000000
0 00000034 00000104 00008001 00000002 1 0 0 0 2 1 0 0 00000000
0 00000038 00000100 00000000 00000000 1 0 a 1 1 2 0 0 8bada50d
0 0000003c 00000100 00000000 00000001 1 0 b 1 1 0 0 0 ffffffa5
0 00000040 00000100 00000000 00000001 1 0 c 1 1 4 0 0 000000a5
0 00000044 00000104 00000000 00000002 1 0 d 1 1 1 0 0 ffff8001
0 00000048 00000104 00000000 00000002 1 0 e 1 1 5 0 0 00008001
0 0000004c 00000200 00000000 00000000 1 0 f 1 1 2 0 0 00000000
0 00000050 00001001 00000000 00000020 1 0 1 1 0 2 1 0 00001020
1 00000054 00000100 deadbeef 00000000 1 0 0 0 2 2 0 0 00000000
1 00000058 00000001 00000001 00000000 0 0 3 1 0 2 0 0 00000002
1 0000005c 00002000 00000000 00000000 1 0 1 1 0 2 1 0 00002000
0 00000060 00000100 00000000 00000000 1 0 2 1 1 2 0 0 8bada50d
0 00000064 00000110 12345678 00000000 1 0 0 0 2 2 0 0 00000000
0 00000068 00000001 00000002 00000000 0 0 4 1 0 2 0 0 00000003
0 0000006c 00000110 00000000 00000000 1 0 5 1 1 2 0 0 12345678
0 00000070 00000110 00000000 00000003 1 0 6 1 1 4 0 0 00000012
0 00000074 00000000 00000001 00000000 0 1 7 1 0 2 0 0 ffffffff
0 00000078 00000000 00000000 00000000 0 0 0 0 0 2 0 1 00000000

// ==== all.f ====
hw/backend_pkg.sv
hw/exe_unit.sv
hw/exe_mem_reg.sv
hw/mem_unit.sv
hw/data_ram.sv
hw/backend_top.sv
verif/backend_assert.sv
verif/tb_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the back end testbench with verilator and run it
verilator --binary --timing --assert -j 0 --top-module tb_backend -f all.f -o tb_backend &&
    ./obj_dir/tb_backend | tee /dev/stderr | grep -q "Test completed successfully" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
